// ==== Bender.yml ====
package:
  name: tomasulo_core

sources:
  - logic/tomasuloPkg.sv
  - logic/tomasuloIfs.sv
  - logic/regStatusTable.sv
  - logic/instDispatch.sv
  - logic/aluResStation.sv
  - logic/aluExec.sv
  - logic/tomasuloCore.sv
  - target: test
    files:
      - test/clockGen.sv
      - test/coreTb.sv

// ==== logic/aluExec.sv ====
`timescale 1ns/1ps

module aluExec import tomasuloPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    issueIf.slave                iss,
    output logic                 cdbValid,
    output logic [tagWidth-1:0]  cdbTag,
    output logic [dataWidth-1:0] cdbData
);

    logic [dataWidth-1:0] result;

    always_comb begin
        result = '0;
        case (iss.op)
            opAdd: result = iss.operandA + iss.operandB;
            opSub: result = iss.operandA - iss.operandB;
            opAnd: result = iss.operandA & iss.operandB;
            opOr:  result = iss.operandA | iss.operandB;
            opXor: result = iss.operandA ^ iss.operandB;
            opSlt: result[0] = $signed(iss.operandA) < $signed(iss.operandB);
            // immediate arrives as operand A
            opLoadImm: result = iss.operandA;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cdbValid <= 1'b0;
        end else begin
            cdbValid <= iss.workEn;
        end
    end

    always_ff @(posedge clk) begin
        if (iss.workEn) begin
            cdbTag  <= iss.destTag;
            cdbData <= result;
        end
    end

endmodule

// ==== logic/aluResStation.sv ====
`timescale 1ns/1ps

module aluResStation import tomasuloPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    dispatchIf.slave             disp,
    issueIf.master               iss,
    input  logic                 cdbValid,
    input  logic [tagWidth-1:0]  cdbTag,
    input  logic [dataWidth-1:0] cdbData
);

    logic [rsSize-1:0]    busy;
    logic [rsSize-1:0]    issued;
    logic [rsSize-1:0]    ready;
    aluOpE                slotOp [rsSize];
    logic [dataWidth-1:0] slotValA [rsSize];
    logic [dataWidth-1:0] slotValB [rsSize];
    logic [tagWidth-1:0]  slotTagA [rsSize];
    logic [tagWidth-1:0]  slotTagB [rsSize];
    logic [tagWidth-1:0]  slotDest [rsSize];
    logic                 issueAny;
    logic [slotWidth-1:0] issueIdx;

    assign disp.freeSlots = ~busy;

    always_comb begin
        for (int k = 0; k < rsSize; k++) begin
            ready[k] = busy[k] && !issued[k]
                && slotTagA[k] == freeTag && slotTagB[k] == freeTag;
        end
    end

    // lowest ready slot wins
    always_comb begin
        issueIdx = '0;
        for (int k = rsSize - 1; k >= 0; k--) begin
            if (ready[k]) begin
                issueIdx = slotWidth'(k);
            end
        end
    end

    assign issueAny = |ready;

    // busy from dispatch until the slot's own tag comes back
    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy   <= '0;
            issued <= '0;
        end else begin
            for (int k = 0; k < rsSize; k++) begin
                if (disp.en && disp.slot == slotWidth'(k)) begin
                    busy[k]   <= 1'b1;
                    issued[k] <= 1'b0;
                end else begin
                    if (issueAny && issueIdx == slotWidth'(k)) begin
                        issued[k] <= 1'b1;
                    end
                    if (busy[k] && cdbValid && slotDest[k] == cdbTag) begin
                        busy[k] <= 1'b0;
                    end
                end
            end
        end
    end

    // slot contents and operand capture
    always_ff @(posedge clk) begin
        for (int k = 0; k < rsSize; k++) begin
            if (disp.en && disp.slot == slotWidth'(k)) begin
                slotOp[k]   <= disp.op;
                slotValA[k] <= disp.valueA;
                slotTagA[k] <= disp.tagA;
                slotValB[k] <= disp.valueB;
                slotTagB[k] <= disp.tagB;
                slotDest[k] <= slotTag(disp.slot);
            end else if (busy[k] && cdbValid) begin
                if (slotTagA[k] != freeTag && slotTagA[k] == cdbTag) begin
                    slotValA[k] <= cdbData;
                    slotTagA[k] <= freeTag;
                end
                if (slotTagB[k] != freeTag && slotTagB[k] == cdbTag) begin
                    slotValB[k] <= cdbData;
                    slotTagB[k] <= freeTag;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            iss.workEn <= 1'b0;
        end else begin
            iss.workEn <= issueAny;
        end
    end

    always_ff @(posedge clk) begin
        if (issueAny) begin
            iss.op       <= slotOp[issueIdx];
            iss.operandA <= slotValA[issueIdx];
            iss.operandB <= slotValB[issueIdx];
            iss.destTag  <= slotDest[issueIdx];
        end
    end

endmodule

// ==== logic/instDispatch.sv ====
`timescale 1ns/1ps

module instDispatch import tomasuloPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    // instruction in
    input  logic                    instValid,
    input  aluOpE                   instOp,
    input  logic [regAddrWidth-1:0] instSrcA,
    input  logic [regAddrWidth-1:0] instSrcB,
    input  logic [regAddrWidth-1:0] instDest,
    input  logic [dataWidth-1:0]    instImm,
    output logic                    instReady,
    // register status table
    output logic [regAddrWidth-1:0] srcA,
    output logic [regAddrWidth-1:0] srcB,
    input  logic [dataWidth-1:0]    valA,
    input  logic [tagWidth-1:0]     tagA,
    input  logic [dataWidth-1:0]    valB,
    input  logic [tagWidth-1:0]     tagB,
    output logic                    renEn,
    output logic [regAddrWidth-1:0] renReg,
    output logic [tagWidth-1:0]     renTag,
    // common data bus
    input  logic                    cdbValid,
    input  logic [tagWidth-1:0]     cdbTag,
    input  logic [dataWidth-1:0]    cdbData,
    dispatchIf.master               disp
);

    logic                 accept;
    logic [slotWidth-1:0] freeIdx;
    logic [rsSize-1:0]    pickMask;
    logic [rsSize-1:0]    releaseMask;
    logic [rsSize-1:0]    nextFree;

    // lowest free slot
    always_comb begin
        freeIdx = '0;
        for (int k = rsSize - 1; k >= 0; k--) begin
            if (disp.freeSlots[k]) begin
                freeIdx = slotWidth'(k);
            end
        end
    end

    assign accept    = instValid && instReady;
    assign disp.en   = accept;
    assign disp.slot = freeIdx;
    assign disp.op   = instOp;

    assign srcA   = instSrcA;
    assign srcB   = instSrcB;
    assign renEn  = accept;
    assign renReg = instDest;
    assign renTag = slotTag(freeIdx);

    // operands with bypass from a result on the bus this cycle
    always_comb begin
        disp.valueA = valA;
        disp.tagA   = tagA;
        disp.valueB = valB;
        disp.tagB   = tagB;
        if (instOp == opLoadImm) begin
            disp.valueA = instImm;
            disp.tagA   = freeTag;
            disp.valueB = '0;
            disp.tagB   = freeTag;
        end else begin
            if (cdbValid && tagA != freeTag && tagA == cdbTag) begin
                disp.valueA = cdbData;
                disp.tagA   = freeTag;
            end
            if (cdbValid && tagB != freeTag && tagB == cdbTag) begin
                disp.valueB = cdbData;
                disp.tagB   = freeTag;
            end
        end
    end

    // free mask as the station will see it after this edge
    always_comb begin
        for (int k = 0; k < rsSize; k++) begin
            pickMask[k]    = accept && freeIdx == slotWidth'(k);
            releaseMask[k] = cdbValid && cdbTag == slotTag(slotWidth'(k));
        end
    end

    assign nextFree = (disp.freeSlots & ~pickMask) | releaseMask;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            instReady <= 1'b1;
        end else begin
            instReady <= |nextFree;
        end
    end

endmodule

// ==== logic/regStatusTable.sv ====
`timescale 1ns/1ps

module regStatusTable import tomasuloPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    // rename from dispatch
    input  logic                    renEn,
    input  logic [regAddrWidth-1:0] renReg,
    input  logic [tagWidth-1:0]     renTag,
    // common data bus
    input  logic                    cdbValid,
    input  logic [tagWidth-1:0]     cdbTag,
    input  logic [dataWidth-1:0]    cdbData,
    // lookups
    input  logic [regAddrWidth-1:0] srcA,
    input  logic [regAddrWidth-1:0] srcB,
    input  logic [regAddrWidth-1:0] regReadAddr,
    output logic [dataWidth-1:0]    valA,
    output logic [tagWidth-1:0]     tagA,
    output logic [dataWidth-1:0]    valB,
    output logic [tagWidth-1:0]     tagB,
    output logic [dataWidth-1:0]    regReadData
);

    logic [dataWidth-1:0] regValue [regCount];
    logic [tagWidth-1:0]  regTag [regCount];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int r = 0; r < regCount; r++) begin
                regValue[r] <= '0;
                regTag[r]   <= freeTag;
            end
        end else begin
            for (int r = 0; r < regCount; r++) begin
                // result for the pending producer of this register
                if (cdbValid && regTag[r] == cdbTag) begin
                    regValue[r] <= cdbData;
                    regTag[r]   <= freeTag;
                end
                // a newer producer wins the tag while the data above still lands
                if (renEn && renReg == regAddrWidth'(r)) begin
                    regTag[r] <= renTag;
                end
            end
        end
    end

    assign valA = regValue[srcA];
    assign tagA = regTag[srcA];
    assign valB = regValue[srcB];
    assign tagB = regTag[srcB];

    assign regReadData = regValue[regReadAddr];

endmodule

// ==== logic/tomasuloCore.sv ====
`timescale 1ns/1ps

module tomasuloCore import tomasuloPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    instValid,
    input  aluOpE                   instOp,
    input  logic [regAddrWidth-1:0] instSrcA,
    input  logic [regAddrWidth-1:0] instSrcB,
    input  logic [regAddrWidth-1:0] instDest,
    input  logic [dataWidth-1:0]    instImm,
    input  logic [regAddrWidth-1:0] regReadAddr,
    output logic                    instReady,
    output logic [dataWidth-1:0]    regReadData,
    output logic                    cdbValid,
    output logic [tagWidth-1:0]     cdbTag,
    output logic [dataWidth-1:0]    cdbData
);

    logic [regAddrWidth-1:0] srcA;
    logic [regAddrWidth-1:0] srcB;
    logic [dataWidth-1:0]    valA;
    logic [tagWidth-1:0]     tagA;
    logic [dataWidth-1:0]    valB;
    logic [tagWidth-1:0]     tagB;
    logic                    renEn;
    logic [regAddrWidth-1:0] renReg;
    logic [tagWidth-1:0]     renTag;

    dispatchIf dispBus ();
    issueIf    issueBus ();

    regStatusTable regTable (
        .clk(clk), .rstN(rstN),
        .renEn(renEn), .renReg(renReg), .renTag(renTag),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData),
        .srcA(srcA), .srcB(srcB), .regReadAddr(regReadAddr),
        .valA(valA), .tagA(tagA), .valB(valB), .tagB(tagB),
        .regReadData(regReadData)
    );

    instDispatch dispatcher (
        .clk(clk), .rstN(rstN),
        .instValid(instValid), .instOp(instOp), .instSrcA(instSrcA),
        .instSrcB(instSrcB), .instDest(instDest), .instImm(instImm),
        .instReady(instReady),
        .srcA(srcA), .srcB(srcB),
        .valA(valA), .tagA(tagA), .valB(valB), .tagB(tagB),
        .renEn(renEn), .renReg(renReg), .renTag(renTag),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData),
        .disp(dispBus.master)
    );

    aluResStation station (
        .clk(clk), .rstN(rstN),
        .disp(dispBus.slave), .iss(issueBus.master),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData)
    );

    aluExec alu (
        .clk(clk), .rstN(rstN),
        .iss(issueBus.slave),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData)
    );

endmodule

// ==== logic/tomasuloIfs.sv ====
`timescale 1ns/1ps

// dispatcher to reservation station
interface dispatchIf import tomasuloPkg::*; ();
    logic                 en;
    logic [slotWidth-1:0] slot;
    aluOpE                op;
    logic [dataWidth-1:0] valueA;
    logic [tagWidth-1:0]  tagA;
    logic [dataWidth-1:0] valueB;
    logic [tagWidth-1:0]  tagB;
    // one bit per slot, high when free
    logic [rsSize-1:0]    freeSlots;

    modport master (output en, slot, op, valueA, tagA, valueB, tagB, input freeSlots);
    modport slave (input en, slot, op, valueA, tagA, valueB, tagB, output freeSlots);
endinterface

// reservation station to ALU
interface issueIf import tomasuloPkg::*; ();
    logic                 workEn;
    aluOpE                op;
    logic [dataWidth-1:0] operandA;
    logic [dataWidth-1:0] operandB;
    logic [tagWidth-1:0]  destTag;

    modport master (output workEn, op, operandA, operandB, destTag);
    modport slave (input workEn, op, operandA, operandB, destTag);
endinterface

// ==== logic/tomasuloPkg.sv ====
package tomasuloPkg;

    // datapath and register file
    localparam int dataWidth    = 32;
    localparam int regCount     = 8;
    localparam int regAddrWidth = 3;

    // reservation station
    localparam int rsSize    = 4;
    localparam int slotWidth = 2;

    // tag k+1 names slot k and tag 0 means the value is present
    localparam int tagWidth = 3;
    localparam logic [tagWidth-1:0] freeTag = '0;

    typedef enum logic [2:0] {
        opAdd     = 3'd0,
        opSub     = 3'd1,
        opAnd     = 3'd2,
        opOr      = 3'd3,
        opXor     = 3'd4,
        opSlt     = 3'd5,
        opLoadImm = 3'd6
    } aluOpE;

    // rename tag owned by a station slot
    function automatic logic [tagWidth-1:0] slotTag(input logic [slotWidth-1:0] slot);
        logic [tagWidth-1:0] tag;
        tag = tagWidth'(slot) + tagWidth'(1);
        return tag;
    endfunction

endpackage

// ==== sim.f ====
logic/tomasuloPkg.sv
logic/tomasuloIfs.sv
logic/regStatusTable.sv
logic/instDispatch.sv
logic/aluResStation.sv
logic/aluExec.sv
logic/tomasuloCore.sv
test/clockGen.sv
test/coreTb.sv

// ==== test/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
    end

endmodule

// ==== test/coreTb.sv ====
`timescale 1ns/1ps

module coreTb import tomasuloPkg::*; ();

    logic                    clk;
    logic                    rstN;
    logic                    instValid;
    aluOpE                   instOp;
    logic [regAddrWidth-1:0] instSrcA;
    logic [regAddrWidth-1:0] instSrcB;
    logic [regAddrWidth-1:0] instDest;
    logic [dataWidth-1:0]    instImm;
    logic [regAddrWidth-1:0] regReadAddr;
    logic                    instReady;
    logic [dataWidth-1:0]    regReadData;
    logic                    cdbValid;
    logic [tagWidth-1:0]     cdbTag;
    logic [dataWidth-1:0]    cdbData;

    // reference model with results kept per station slot
    logic [dataWidth-1:0] regModel [regCount];
    logic [dataWidth-1:0] expValue [rsSize];
    int                   acceptEdge [rsSize];
    logic [rsSize-1:0]    busyMask;
    logic [rsSize-1:0]    busySnap;
    int                   pendingCount;
    int                   cycleCount;
    int                   errorCount;
    bit                   checkLatency;
    string                testName;
    logic [31:0]          lfsrState;

    clockGen clocks (.clk(clk), .rstN(rstN));

    tomasuloCore UUT (
        .clk(clk), .rstN(rstN),
        .instValid(instValid), .instOp(instOp), .instSrcA(instSrcA),
        .instSrcB(instSrcB), .instDest(instDest), .instImm(instImm),
        .regReadAddr(regReadAddr), .instReady(instReady), .regReadData(regReadData),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
    endtask

    function automatic logic [dataWidth-1:0] refResult(input aluOpE op,
            input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b,
            input logic [dataWidth-1:0] imm);
        case (op)
            opAdd:     return a + b;
            opSub:     return a - b;
            opAnd:     return a & b;
            opOr:      return a | b;
            opXor:     return a ^ b;
            opSlt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            opLoadImm: return imm;
            default:   return '0;
        endcase
    endfunction

    task automatic stopOnTimeout(input string what);
        $display("timeout in %s: %s", testName, what);
        $display("errors: %0d", errorCount + 1);
        $display("Something failed");
        $finish;
    endtask

    // lowest free slot of the mask seen before the accepting edge
    task automatic recordAccept(input logic [rsSize-1:0] mask);
        int slot;
        logic [dataWidth-1:0] value;
        slot = -1;
        for (int k = rsSize - 1; k >= 0; k--) begin
            if (!mask[k]) slot = k;
        end
        if (slot < 0) begin
            $display("%s: instruction accepted while every slot is busy", testName);
            errorCount++;
        end else begin
            value = refResult(instOp, regModel[instSrcA], regModel[instSrcB], instImm);
            regModel[instDest] = value;
            busyMask[slot] = 1'b1;
            expValue[slot] = value;
            acceptEdge[slot] = cycleCount + 1;
            pendingCount++;
        end
    endtask

    task automatic checkResult();
        int slot;
        slot = int'(cdbTag) - 1;
        if (slot < 0 || slot >= rsSize || !busySnap[slot]) begin
            $display("%s: CDB carries tag %0d with nothing pending", testName, cdbTag);
            errorCount++;
        end else begin
            if (cdbData !== expValue[slot]) begin
                $display("mismatch %s: tag %0d expected %h actual %h",
                    testName, cdbTag, expValue[slot], cdbData);
                errorCount++;
            end
            if (checkLatency && cycleCount - acceptEdge[slot] != 2) begin
                $display("mismatch %s: latency expected 2 actual %0d",
                    testName, cycleCount - acceptEdge[slot]);
                errorCount++;
            end
            busyMask[slot] = 1'b0;
            pendingCount--;
        end
    endtask

    always @(posedge clk) cycleCount++;

    // score CDB results and record accepted instructions mid-cycle
    always @(negedge clk) begin
        if (rstN) begin
            busySnap = busyMask;
            if (cdbValid) checkResult();
            if (instValid && instReady) recordAccept(busySnap);
        end
    end

    task automatic sendInst(input aluOpE op, input logic [regAddrWidth-1:0] a,
            input logic [regAddrWidth-1:0] b, input logic [regAddrWidth-1:0] d,
            input logic [dataWidth-1:0] imm);
        int waited;
        waited = 0;
        while (!instReady) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 100) stopOnTimeout("instReady stayed low");
        end
        instValid = 1'b1;
        instOp = op;
        instSrcA = a;
        instSrcB = b;
        instDest = d;
        instImm = imm;
        @(posedge clk);
        #1;
        instValid = 1'b0;
    endtask

    task automatic waitIdle();
        int waited;
        waited = 0;
        while (pendingCount != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 100) stopOnTimeout("results never came back on the CDB");
        end
    endtask

    task automatic readReg(input int r, output logic [dataWidth-1:0] value);
        regReadAddr = regAddrWidth'(r);
        @(negedge clk);
        value = regReadData;
        @(posedge clk);
        #1;
    endtask

    task automatic checkRegs();
        logic [dataWidth-1:0] value;
        for (int r = 0; r < regCount; r++) begin
            readReg(r, value);
            if (value !== regModel[r]) begin
                $display("mismatch %s: r%0d expected %h actual %h",
                    testName, r, regModel[r], value);
                errorCount++;
            end
        end
    endtask

    task automatic resetState();
        testName = "reset";
        if (instReady !== 1'b1) begin
            $display("mismatch %s: instReady expected 1 actual %b", testName, instReady);
            errorCount++;
        end
        if (cdbValid !== 1'b0) begin
            $display("mismatch %s: cdbValid expected 0 actual %b", testName, cdbValid);
            errorCount++;
        end
        checkRegs();
    endtask

    task automatic independentOps();
        testName = "independent";
        checkLatency = 1'b1;
        sendInst(opLoadImm, 3'd0, 3'd0, 3'd1, 32'hffff_fff0);
        waitIdle();
        sendInst(opLoadImm, 3'd0, 3'd0, 3'd2, 32'h0000_0025);
        waitIdle();
        for (int i = 0; i < 6; i++) begin
            sendInst(aluOpE'(i), 3'd1, 3'd2, regAddrWidth'(3 + i % 5), '0);
            waitIdle();
        end
        // positive against negative
        sendInst(opSlt, 3'd2, 3'd1, 3'd7, '0);
        waitIdle();
        checkLatency = 1'b0;
        checkRegs();
    endtask

    task automatic rawChain();
        testName = "rawChain";
        sendInst(opLoadImm, 3'd0, 3'd0, 3'd1, 32'h0000_1234);
        sendInst(opAdd, 3'd1, 3'd1, 3'd2, '0);
        sendInst(opOr, 3'd2, 3'd2, 3'd5, '0);
        // r1 is on the CDB while this one is accepted
        sendInst(opSub, 3'd1, 3'd2, 3'd3, '0);
        sendInst(opXor, 3'd3, 3'd5, 3'd4, '0);
        waitIdle();
        checkRegs();
    endtask

    task automatic wawRename();
        logic [dataWidth-1:0] value;
        testName = "wawRename";
        sendInst(opLoadImm, 3'd0, 3'd0, 3'd6, 32'h0000_0aaa);
        sendInst(opLoadImm, 3'd0, 3'd0, 3'd6, 32'h0000_0555);
        sendInst(opOr, 3'd6, 3'd6, 3'd7, '0);
        waitIdle();
        readReg(6, value);
        if (value !== 32'h0000_0555) begin
            $display("mismatch %s: r6 expected %h actual %h", testName, 32'h555, value);
            errorCount++;
        end
        readReg(7, value);
        if (value !== 32'h0000_0555) begin
            $display("mismatch %s: r7 expected %h actual %h", testName, 32'h555, value);
            errorCount++;
        end
    endtask

    task automatic randomStream();
        logic [31:0] bits;
        logic [31:0] imm;
        aluOpE op;
        logic [regAddrWidth-1:0] a;
        logic [regAddrWidth-1:0] b;
        logic [regAddrWidth-1:0] d;
        testName = "randomStream";
        for (int n = 0; n < 200; n++) begin
            randBits(3, bits);
            op = (bits[2:0] == 3'd7) ? opLoadImm : aluOpE'(bits[2:0]);
            randBits(3, bits);
            a = bits[2:0];
            randBits(3, bits);
            b = bits[2:0];
            randBits(3, bits);
            d = bits[2:0];
            randBits(32, imm);
            sendInst(op, a, b, d, imm);
        end
        waitIdle();
        checkRegs();
    endtask

    initial begin
        int waited;
        instValid = 1'b0;
        instOp = opAdd;
        instSrcA = '0;
        instSrcB = '0;
        instDest = '0;
        instImm = '0;
        regReadAddr = '0;
        busyMask = '0;
        pendingCount = 0;
        cycleCount = 0;
        errorCount = 0;
        checkLatency = 1'b0;
        lfsrState = 32'hd2d7;
        testName = "reset";
        for (int r = 0; r < regCount; r++) regModel[r] = '0;
        waited = 0;
        while (!rstN) begin
            @(negedge clk);
            waited++;
            if (waited > 50) stopOnTimeout("reset was never released");
        end
        @(posedge clk);
        #1;
        resetState();
        independentOps();
        rawChain();
        wawRename();
        randomStream();
        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
